//--- project.f
source/fir_pkg.sv
source/coeff_loader.sv
source/tap_bank.sv
source/fir_combiner.sv
source/rx_fir_top.sv
test/coeff_ram_model.sv
test/rx_fir_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module rx_fir_tb -o rx_fir_sim

./obj_dir/rx_fir_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "rx_fir_tb: passed"
else
    echo "rx_fir_tb: failed, see sim.log"
    exit 1
fi

//--- source/coeff_loader.sv
`timescale 1ns/1ps

module coeff_loader import fir_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       en,
    input  logic signed [COEFF_W-1:0]  ram_data,
    output logic        [ADDR_W-1:0]   ram_addr,
    output logic                       coeff_wr,
    output logic        [TAP_W-1:0]    coeff_index,
    output logic signed [COEFF_W-1:0]  coeff_data,
    output logic                       coeff_ready
);

    logic                   issue;
    logic                   issue_done;
    logic [RAM_LATENCY-1:0] wr_pipe;
    logic [TAP_W-1:0]       index_pipe [RAM_LATENCY];

    // One read request per cycle until the last tap address is out
    assign issue = en && !issue_done;

    ////////////////////////////////////////////////////////////////////////////
    // Address counter and request tracking
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_addr    <= '0;
            issue_done  <= 1'b0;
            wr_pipe     <= '0;
            coeff_wr    <= 1'b0;
            coeff_ready <= 1'b0;
        end else begin
            if (issue) begin
                if (ram_addr == ADDR_W'(NUM_TAPS - 1)) begin
                    issue_done <= 1'b1;
                end else begin
                    ram_addr <= ram_addr + 1'b1;
                end
            end
            wr_pipe  <= {wr_pipe[RAM_LATENCY-2:0], issue};
            coeff_wr <= wr_pipe[RAM_LATENCY-1];
            // Ready once the last tap has landed in its bank
            if (coeff_wr && coeff_index == TAP_W'(NUM_TAPS - 1)) begin
                coeff_ready <= 1'b1;
            end
        end
    end

    // Index follows the strobe so it lines up with the RAM data
    always_ff @(posedge clk) begin
        index_pipe[0] <= ram_addr[TAP_W-1:0];
        for (int i = 1; i < RAM_LATENCY; i++) begin
            index_pipe[i] <= index_pipe[i-1];
        end
        coeff_index <= index_pipe[RAM_LATENCY-1];
        coeff_data  <= ram_data;
    end

    a_index_range: assert property (
        @(posedge clk) disable iff (reset)
        coeff_wr |-> (coeff_index < TAP_W'(NUM_TAPS))
    );

endmodule

//--- source/fir_combiner.sv
`timescale 1ns/1ps

module fir_combiner import fir_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       en,
    input  logic        [1:0]          gain,
    input  logic        [1:0]          deci,
    input  logic signed [SAMPLE_W-1:0] in,
    input  logic signed [PROD_W-1:0]   sum_a,
    input  logic signed [PROD_W-1:0]   sum_b,
    output logic signed [SAMPLE_W-1:0] out,
    output logic                       out_valid
);

    logic signed [SAMPLE_W-1:0] sum_hi;
    logic signed [SAMPLE_W-1:0] gained;
    logic        [1:0]          deci_cnt;
    logic        [1:0]          deci_last;
    logic                       deci_ok;

    // Upper halves of both partial sums, wraps at 16 bits
    always_ff @(posedge clk) begin
        sum_hi <= sum_a[PROD_W-1 -: SAMPLE_W] + sum_b[PROD_W-1 -: SAMPLE_W];
    end

    // Gain stage
    always_ff @(posedge clk) begin
        case (gain)
            GAIN_P6DB:  gained <= sum_hi <<< 1;
            GAIN_0DB:   gained <= sum_hi;
            GAIN_M6DB:  gained <= sum_hi >>> 1;
            GAIN_M12DB: gained <= sum_hi >>> 2;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decimation and bypass
    ////////////////////////////////////////////////////////////////////////////

    assign deci_ok = (deci == DECI_1) || (deci == DECI_2) || (deci == DECI_4);

    always_comb begin
        case (deci)
            DECI_2:  deci_last = 2'd1;
            DECI_4:  deci_last = 2'd3;
            default: deci_last = 2'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out       <= '0;
            out_valid <= 1'b0;
            deci_cnt  <= '0;
        end else if (!en) begin
            // Filter off, input goes straight out
            out       <= in;
            out_valid <= 1'b0;
            deci_cnt  <= '0;
        end else if (deci_ok) begin
            if (deci_cnt == deci_last) begin
                out       <= gained;
                out_valid <= 1'b1;
                deci_cnt  <= '0;
            end else begin
                out_valid <= 1'b0;
                deci_cnt  <= deci_cnt + 1'b1;
            end
        end else begin
            out       <= '0;
            out_valid <= 1'b0;
            deci_cnt  <= '0;
        end
    end

    a_no_valid_after_disable: assert property (
        @(posedge clk) disable iff (reset)
        !en |=> !out_valid
    );

endmodule

//--- source/fir_pkg.sv
package fir_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data path widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int SAMPLE_W = 16;
    localparam int COEFF_W  = 16;
    // Full product of sample and coefficient, also the partial sum width
    localparam int PROD_W   = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Filter geometry and coefficient RAM
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_TAPS  = 24;
    localparam int BANK_TAPS = 12;
    localparam int ADDR_W    = 7;
    localparam int TAP_W     = 5;

    // Read latency of the external coefficient RAM
    localparam int RAM_LATENCY = 2;

    // Sample at bank input to partial sum
    localparam int BANK_LATENCY    = 5;
    // Partial sums to filter output
    localparam int COMBINE_LATENCY = 3;

    ////////////////////////////////////////////////////////////////////////////
    // Control codes
    ////////////////////////////////////////////////////////////////////////////

    // Gain settings
    localparam logic [1:0] GAIN_P6DB  = 2'd0;
    localparam logic [1:0] GAIN_0DB   = 2'd1;
    localparam logic [1:0] GAIN_M6DB  = 2'd2;
    localparam logic [1:0] GAIN_M12DB = 2'd3;

    // Decimation rates, code 0 not allowed
    localparam logic [1:0] DECI_1 = 2'd1;
    localparam logic [1:0] DECI_2 = 2'd2;
    localparam logic [1:0] DECI_4 = 2'd3;

endpackage

//--- source/rx_fir_top.sv
`timescale 1ns/1ps

module rx_fir_top import fir_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       en,
    input  logic        [1:0]          gain,
    input  logic        [1:0]          deci,
    input  logic signed [SAMPLE_W-1:0] in,
    input  logic signed [COEFF_W-1:0]  ram_data,
    output logic signed [SAMPLE_W-1:0] out,
    output logic                       out_valid,
    output logic        [ADDR_W-1:0]   ram_addr
);

    logic                       coeff_wr;
    logic        [TAP_W-1:0]    coeff_index;
    logic signed [COEFF_W-1:0]  coeff_data;
    logic                       coeff_ready;
    logic signed [SAMPLE_W-1:0] sample_mid;
    logic signed [PROD_W-1:0]   sum_a;
    logic signed [PROD_W-1:0]   sum_b;

    coeff_loader loader_i (
        .clk         (clk),
        .reset       (reset),
        .en          (en),
        .ram_data    (ram_data),
        .ram_addr    (ram_addr),
        .coeff_wr    (coeff_wr),
        .coeff_index (coeff_index),
        .coeff_data  (coeff_data),
        .coeff_ready (coeff_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Two banks chained into one 24-tap delay line
    ////////////////////////////////////////////////////////////////////////////

    tap_bank #(.FIRST_TAP(0)) bank_a (
        .clk         (clk),
        .reset       (reset),
        .coeff_ready (coeff_ready),
        .coeff_wr    (coeff_wr),
        .coeff_index (coeff_index),
        .coeff_data  (coeff_data),
        .sample_in   (in),
        .sample_out  (sample_mid),
        .partial_sum (sum_a)
    );

    tap_bank #(.FIRST_TAP(BANK_TAPS)) bank_b (
        .clk         (clk),
        .reset       (reset),
        .coeff_ready (coeff_ready),
        .coeff_wr    (coeff_wr),
        .coeff_index (coeff_index),
        .coeff_data  (coeff_data),
        .sample_in   (sample_mid),
        .sample_out  (),
        .partial_sum (sum_b)
    );

    fir_combiner combiner_i (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .gain      (gain),
        .deci      (deci),
        .in        (in),
        .sum_a     (sum_a),
        .sum_b     (sum_b),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

//--- source/tap_bank.sv
`timescale 1ns/1ps

module tap_bank import fir_pkg::*; #(
    parameter int FIRST_TAP = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       coeff_ready,
    input  logic                       coeff_wr,
    input  logic        [TAP_W-1:0]    coeff_index,
    input  logic signed [COEFF_W-1:0]  coeff_data,
    input  logic signed [SAMPLE_W-1:0] sample_in,
    output logic signed [SAMPLE_W-1:0] sample_out,
    output logic signed [PROD_W-1:0]   partial_sum
);

    logic signed [COEFF_W-1:0]  coeff  [BANK_TAPS];
    logic signed [SAMPLE_W-1:0] delay  [BANK_TAPS];
    logic signed [PROD_W-1:0]   prod   [BANK_TAPS];
    logic signed [PROD_W-1:0]   sum_l1 [BANK_TAPS/2];
    logic signed [PROD_W-1:0]   sum_l2 [BANK_TAPS/4];
    logic signed [PROD_W-1:0]   sum_l3 [2];

    ////////////////////////////////////////////////////////////////////////////
    // Coefficient registers
    ////////////////////////////////////////////////////////////////////////////

    // Only indices inside this bank's range are kept
    always_ff @(posedge clk) begin
        for (int j = 0; j < BANK_TAPS; j++) begin
            if (coeff_wr && coeff_index == TAP_W'(FIRST_TAP + j)) begin
                coeff[j] <= coeff_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Delay line
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        delay[0] <= sample_in;
        for (int j = 1; j < BANK_TAPS; j++) begin
            delay[j] <= delay[j-1];
        end
    end

    // Oldest sample feeds the next bank
    assign sample_out = delay[BANK_TAPS-1];

    ////////////////////////////////////////////////////////////////////////////
    // Multipliers and adder tree
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int j = 0; j < BANK_TAPS; j++) begin
            if (!coeff_ready) begin
                prod[j] <= '0;
            end else begin
                prod[j] <= coeff[j] * delay[j];
            end
        end
    end

    // 12 to 6 to 3 to 2 to 1, one register per level
    always_ff @(posedge clk) begin
        for (int i = 0; i < BANK_TAPS/2; i++) begin
            sum_l1[i] <= prod[2*i] + prod[2*i+1];
        end
        for (int i = 0; i < BANK_TAPS/4; i++) begin
            sum_l2[i] <= sum_l1[2*i] + sum_l1[2*i+1];
        end
        sum_l3[0]   <= sum_l2[0] + sum_l2[1];
        sum_l3[1]   <= sum_l2[2];
        partial_sum <= sum_l3[0] + sum_l3[1];
    end

    // Loader must be done writing before products are released
    a_no_write_when_ready: assert property (
        @(posedge clk) disable iff (reset)
        !(coeff_wr && coeff_ready)
    );

endmodule

//--- test/coeff_ram_model.sv
`timescale 1ns/1ps

module coeff_ram_model import fir_pkg::*; (
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic        [ADDR_W-1:0]  wr_addr,
    input  logic signed [COEFF_W-1:0] wr_data,
    input  logic        [ADDR_W-1:0]  rd_addr,
    output logic signed [COEFF_W-1:0] rd_data
);

    logic signed [COEFF_W-1:0] mem [2**ADDR_W];
    logic signed [COEFF_W-1:0] rd_stage;

    // Words nobody writes still carry their own address
    initial begin
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a] = {1'b1, ADDR_W'(a), 1'b0, ADDR_W'(a)};
        end
    end

    // Two register stages on the read side
    always @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_stage <= mem[rd_addr];
        rd_data  <= rd_stage;
    end

endmodule

//--- test/rx_fir_tb.sv
`timescale 1ns/1ps

module rx_fir_tb import fir_pkg::*; ();

    // Whole sequence is about 1450 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                       clk;
    logic                       reset;
    logic                       en;
    logic        [1:0]          gain;
    logic        [1:0]          deci;
    logic signed [SAMPLE_W-1:0] in;
    logic signed [COEFF_W-1:0]  ram_data;
    logic signed [SAMPLE_W-1:0] out;
    logic                       out_valid;
    logic        [ADDR_W-1:0]   ram_addr;
    logic                       ram_we;
    logic        [ADDR_W-1:0]   ram_waddr;
    logic signed [COEFF_W-1:0]  ram_wdata;

    logic signed [COEFF_W-1:0]  coeffs     [NUM_TAPS];
    // Inputs as the DUT saw them at each rising edge
    logic signed [SAMPLE_W-1:0] x_hist     [TIMEOUT_CYCLES+1];
    logic                       reset_hist [TIMEOUT_CYCLES+1];
    logic                       en_hist    [TIMEOUT_CYCLES+1];
    logic        [1:0]          gain_hist  [TIMEOUT_CYCLES+1];
    logic        [1:0]          deci_hist  [TIMEOUT_CYCLES+1];

    int   cycle;
    int   filter_start;
    int   last_valid;
    logic spacing_known;
    int   check_count;
    int   error_count;

    rx_fir_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .en        (en),
        .gain      (gain),
        .deci      (deci),
        .in        (in),
        .ram_data  (ram_data),
        .out       (out),
        .out_valid (out_valid),
        .ram_addr  (ram_addr)
    );

    coeff_ram_model ram_i (
        .clk     (clk),
        .wr_en   (ram_we),
        .wr_addr (ram_waddr),
        .wr_data (ram_wdata),
        .rd_addr (ram_addr),
        .rd_data (ram_data)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name,
                               input logic signed [31:0] actual,
                               input logic signed [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic next_sample();
        @(negedge clk);
        in = SAMPLE_W'($urandom);
    endtask

    task automatic run_samples(input int count);
        repeat (count) next_sample();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Filter output for the sample taken at edge n
    function automatic logic signed [SAMPLE_W-1:0] expected_output(input int n,
                                                                   input logic [1:0] g);
        logic signed [PROD_W-1:0]   acc_a;
        logic signed [PROD_W-1:0]   acc_b;
        logic signed [SAMPLE_W-1:0] hi;
        logic signed [SAMPLE_W-1:0] result;
        acc_a = '0;
        acc_b = '0;
        for (int t = 0; t < BANK_TAPS; t++) begin
            acc_a = acc_a + PROD_W'(coeffs[t]) * PROD_W'(x_hist[n-t]);
            acc_b = acc_b + PROD_W'(coeffs[t+BANK_TAPS]) * PROD_W'(x_hist[n-t-BANK_TAPS]);
        end
        hi = acc_a[PROD_W-1 -: SAMPLE_W] + acc_b[PROD_W-1 -: SAMPLE_W];
        case (g)
            GAIN_P6DB:  result = hi <<< 1;
            GAIN_0DB:   result = hi;
            GAIN_M6DB:  result = hi >>> 1;
            GAIN_M12DB: result = hi >>> 2;
        endcase
        return result;
    endfunction

    function automatic int deci_period(input logic [1:0] d);
        case (d)
            DECI_2:  return 2;
            DECI_4:  return 4;
            default: return 1;
        endcase
    endfunction

    always @(posedge clk) begin
        cycle             = cycle + 1;
        x_hist[cycle]     = in;
        reset_hist[cycle] = reset;
        en_hist[cycle]    = en;
        gain_hist[cycle]  = gain;
        deci_hist[cycle]  = deci;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: test sequence still running after %0d cycles", cycle);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Outputs are read half a cycle after the edge that set them
    always @(negedge clk) begin
        int c;
        c = cycle;
        if (!reset_hist[c]) begin
            if (!en_hist[c]) begin
                check_value("out", out, x_hist[c]);
                check_value("out_valid", out_valid, 0);
                // Decimation counter restarts here
                last_valid    = c;
                spacing_known = 1'b1;
            end else if (c < filter_start) begin
                spacing_known = 1'b0;
            end else if (out_valid) begin
                check_value("out", out,
                            expected_output(c - BANK_LATENCY - COMBINE_LATENCY,
                                            gain_hist[c-1]));
                if (spacing_known && deci_hist[c] == deci_hist[last_valid]) begin
                    check_value("out_valid spacing", c - last_valid, deci_period(deci_hist[c]));
                end
                last_valid    = c;
                spacing_known = 1'b1;
                check_count++;
            end else if (spacing_known && c - last_valid >= 4) begin
                check_value("out_valid", out_valid, 1);
                spacing_known = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int wait_count;
        clk           = 1'b0;
        reset         = 1'b1;
        en            = 1'b0;
        gain          = GAIN_0DB;
        deci          = DECI_1;
        in            = '0;
        ram_we        = 1'b0;
        ram_waddr     = '0;
        ram_wdata     = '0;
        cycle         = 0;
        filter_start  = TIMEOUT_CYCLES;
        last_valid    = 0;
        spacing_known = 1'b0;
        check_count   = 0;
        error_count   = 0;
        void'($urandom(32'hc494_77e4));
        for (int k = 0; k < NUM_TAPS; k++) begin
            coeffs[k] = COEFF_W'($urandom);
        end

        run_samples(4);
        check_value("out", out, 0);
        check_value("out_valid", out_valid, 0);
        check_value("ram_addr", ram_addr, 0);
        reset = 1'b0;

        // Fill the RAM while the filter is bypassed
        for (int k = 0; k < NUM_TAPS; k++) begin
            ram_we    = 1'b1;
            ram_waddr = ADDR_W'(k);
            ram_wdata = coeffs[k];
            next_sample();
        end
        ram_we = 1'b0;
        check_value("ram_addr", ram_addr, 0);

        en = 1'b1;
        for (int k = 1; k < NUM_TAPS; k++) begin
            next_sample();
            check_value("ram_addr", ram_addr, k);
        end
        wait_count = 0;
        while (!dut_i.loader_i.coeff_ready && wait_count < 2 * NUM_TAPS) begin
            next_sample();
            check_value("ram_addr", ram_addr, NUM_TAPS - 1);
            wait_count++;
        end
        if (!dut_i.loader_i.coeff_ready) begin
            $display("Error: coeff_ready did not rise after the coefficient load");
            error_count++;
        end
        filter_start = cycle + NUM_TAPS;

        run_samples(NUM_TAPS + 400);
        for (int g = 0; g < 4; g++) begin
            gain = 2'(g);
            run_samples(100);
        end
        gain = GAIN_0DB;
        deci = DECI_2;
        run_samples(200);
        deci = DECI_4;
        run_samples(200);

        // Bypass, then back to filtering without a reload
        en = 1'b0;
        run_samples(50);
        en = 1'b1;
        run_samples(40);
        @(posedge clk);

        if (check_count == 0) begin
            $display("Error: no filter output was compared");
            error_count++;
        end
        $display("Compared %0d filter outputs, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
